/* Bender.yml */
package:
  name: hacd

sources:
  - files:
      - design/hacd_noc_pkg.sv
      - design/hacd_reg_pkg.sv
      - design/hacd_if.sv
      - design/hacd_noc_rx.sv
      - design/hacd_pipe_reg.sv
      - design/hacd_word_split.sv
      - design/hacd_ctrl_regs.sv
      - design/hacd_noc_tx.sv
      - design/hacd_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_hacd_top.sv

/* design/hacd_ctrl_regs.sv */
// job registers, deflate/inflate job sequencing, done flags and interrupts
`default_nettype none

module hacd_ctrl_regs #(
  parameter int unsigned LenWidth = 8
) (
  input  wire logic clk_i,
  input  wire logic rst_ni,
  reg_bus_if.slv    bus,
  output logic      infl_irq_o,
  output logic      defl_irq_o
);

  import hacd_reg_pkg::*;

  // engine index
  localparam int unsigned EngDefl = 0;
  localparam int unsigned EngInfl = 1;

  logic [31:0]                src_lo_q;
  logic [31:0]                src_hi_q;
  logic [LenWidth-1:0]        len_q;
  logic [31:0]                job_cnt_q;
  logic [1:0]                 busy_q;
  logic [1:0]                 done_q;
  logic [1:0][LenWidth-1:0]   cnt_q;
  logic [1:0]                 start;
  logic [1:0]                 clear;
  logic [1:0]                 finish;
  logic                       wr_en;
  logic [31:0]                status;

  assign wr_en = bus.req.valid & bus.req.write;

  assign start[EngDefl]  = wr_en && (bus.req.addr == RegCtrl) && bus.req.wdata[CtrlDeflStart];
  assign start[EngInfl]  = wr_en && (bus.req.addr == RegCtrl) && bus.req.wdata[CtrlInflStart];
  assign clear[EngDefl]  = wr_en && (bus.req.addr == RegStatus) && bus.req.wdata[StDeflDone];
  assign clear[EngInfl]  = wr_en && (bus.req.addr == RegStatus) && bus.req.wdata[StInflDone];

  // last busy cycle of each engine
  assign finish = busy_q & {(cnt_q[EngInfl] == '0), (cnt_q[EngDefl] == '0)};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      src_lo_q  <= '0;
      src_hi_q  <= '0;
      len_q     <= '0;
      job_cnt_q <= '0;
      busy_q    <= '0;
      done_q    <= '0;
      cnt_q     <= '0;
    end else begin
      if (wr_en && bus.req.addr == RegSrcLo) src_lo_q <= bus.req.wdata;
      if (wr_en && bus.req.addr == RegSrcHi) src_hi_q <= bus.req.wdata;
      if (wr_en && bus.req.addr == RegLen)   len_q    <= bus.req.wdata[LenWidth-1:0];
      job_cnt_q <= job_cnt_q + 32'(finish[EngDefl]) + 32'(finish[EngInfl]);

      ////////////////////////////////////////////////////////////
      // countdown engines
      ////////////////////////////////////////////////////////////
      for (int i = 0; i < 2; i++) begin
        if (busy_q[i]) begin
          // a start while busy is dropped
          if (finish[i]) begin
            busy_q[i] <= 1'b0;
          end else begin
            cnt_q[i] <= cnt_q[i] - 1'b1;
          end
        end else if (start[i]) begin
          busy_q[i] <= 1'b1;
          cnt_q[i]  <= len_q;
        end
        // finishing wins over a clear in the same cycle
        if (finish[i]) begin
          done_q[i] <= 1'b1;
        end else if (clear[i]) begin
          done_q[i] <= 1'b0;
        end
      end
    end
  end

  always_comb begin
    status             = '0;
    status[StDeflBusy] = busy_q[EngDefl];
    status[StInflBusy] = busy_q[EngInfl];
    status[StDeflDone] = done_q[EngDefl];
    status[StInflDone] = done_q[EngInfl];
  end

  // read mux, ctrl and unmapped offsets read as zero
  always_comb begin
    unique case (bus.req.addr)
      RegStatus: bus.rsp.rdata = status;
      RegSrcLo:  bus.rsp.rdata = src_lo_q;
      RegSrcHi:  bus.rsp.rdata = src_hi_q;
      RegLen:    bus.rsp.rdata = 32'(len_q);
      RegJobCnt: bus.rsp.rdata = job_cnt_q;
      default:   bus.rsp.rdata = '0;
    endcase
  end

  assign bus.rsp.ready = 1'b1;

  assign defl_irq_o = done_q[EngDefl];
  assign infl_irq_o = done_q[EngInfl];

endmodule

`default_nettype wire

/* design/hacd_if.sv */
// internal request, register bus and response interfaces of the front end
`default_nettype none

////////////////////////////////////////////////////////////
// whole requests, receive side towards the splitter
////////////////////////////////////////////////////////////
interface acc_req_if;
  logic                   valid;
  logic                   ready;
  hacd_noc_pkg::acc_req_t data;

  modport src (
    output valid,
    output data,
    input  ready
  );

  modport dst (
    input  valid,
    input  data,
    output ready
  );
endinterface

////////////////////////////////////////////////////////////
// 32-bit register accesses
////////////////////////////////////////////////////////////
interface reg_bus_if;
  hacd_reg_pkg::reg_req_t req;
  hacd_reg_pkg::reg_rsp_t rsp;

  modport mst (
    output req,
    input  rsp
  );

  modport slv (
    input  req,
    output rsp
  );
endinterface

////////////////////////////////////////////////////////////
// whole responses, splitter towards the transmit side
////////////////////////////////////////////////////////////
interface acc_rsp_if;
  logic                   valid;
  logic                   ready;
  hacd_noc_pkg::acc_rsp_t data;

  modport src (
    output valid,
    output data,
    input  ready
  );

  modport dst (
    input  valid,
    input  data,
    output ready
  );
endinterface

`default_nettype wire

/* design/hacd_noc_pkg.sv */
// noc packet format and whole request/response types for the accelerator front end
`default_nettype none

package hacd_noc_pkg;

  // flit width on both noc directions
  localparam int unsigned NocDataWidth = 32;

  // packet opcodes, carried in the header flit
  typedef enum logic [1:0] {
    OpRead  = 2'd0,
    OpWrite = 2'd1,
    OpAck   = 2'd2,
    OpRdata = 2'd3
  } noc_op_e;

  // header flit field positions
  localparam int unsigned HdrOpMsb   = 31;
  localparam int unsigned HdrOpLsb   = 30;
  localparam int unsigned HdrSizeBit = 29;

  // one complete request as gathered from the noc
  typedef struct packed {
    logic        write;
    logic        size64;
    logic [31:0] addr;
    logic [63:0] wdata;
  } acc_req_t;

  // one complete response before serialization
  typedef struct packed {
    logic        write;
    logic        size64;
    logic [63:0] rdata;
  } acc_rsp_t;

endpackage

`default_nettype wire

/* design/hacd_noc_rx.sv */
// noc receive stage, gathers request flits into one whole request
`default_nettype none

module hacd_noc_rx (
  input  wire logic                                  clk_i,
  input  wire logic                                  rst_ni,
  input  wire logic [hacd_noc_pkg::NocDataWidth-1:0] noc_data_i,
  input  wire logic                                  noc_valid_i,
  output logic                                       noc_ready_o,
  acc_req_if.src                                     req
);

  import hacd_noc_pkg::*;

  logic [1:0]  cnt_q;
  logic [1:0]  last_cnt;
  logic        write_q;
  logic        size64_q;
  logic        valid_q;
  logic [31:0] addr_q;
  logic [63:0] wdata_q;
  logic        flit_fire;

  // stall the noc while a finished request waits downstream
  assign noc_ready_o = ~valid_q;
  assign flit_fire   = noc_valid_i & noc_ready_o;

  // header, address, then one or two data words for writes
  assign last_cnt = !write_q ? 2'd1 : (size64_q ? 2'd3 : 2'd2);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q    <= '0;
      write_q  <= 1'b0;
      size64_q <= 1'b0;
      valid_q  <= 1'b0;
    end else begin
      if (req.valid && req.ready) begin
        valid_q <= 1'b0;
      end
      if (flit_fire) begin
        if (cnt_q == 2'd0) begin
          write_q  <= (noc_op_e'(noc_data_i[HdrOpMsb:HdrOpLsb]) == OpWrite);
          size64_q <= noc_data_i[HdrSizeBit];
          cnt_q    <= 2'd1;
        end else if (cnt_q == last_cnt) begin
          cnt_q   <= 2'd0;
          valid_q <= 1'b1;
        end else begin
          cnt_q <= cnt_q + 2'd1;
        end
      end
    end
  end

  // address and data words, low word first
  always_ff @(posedge clk_i) begin
    if (flit_fire) begin
      case (cnt_q)
        2'd1:    addr_q          <= noc_data_i;
        2'd2:    wdata_q[31:0]   <= noc_data_i;
        2'd3:    wdata_q[63:32]  <= noc_data_i;
        default: ;
      endcase
    end
  end

  assign req.valid = valid_q;
  assign req.data  = '{write: write_q, size64: size64_q, addr: addr_q, wdata: wdata_q};

endmodule

`default_nettype wire

/* design/hacd_noc_tx.sv */
// noc transmit stage, serializes responses into flits under back-pressure
`default_nettype none

module hacd_noc_tx (
  input  wire logic                                  clk_i,
  input  wire logic                                  rst_ni,
  acc_rsp_if.dst                                     rsp,
  output logic [hacd_noc_pkg::NocDataWidth-1:0]      noc_data_o,
  output logic                                       noc_valid_o,
  input  wire logic                                  noc_ready_i
);

  import hacd_noc_pkg::*;

  logic        busy_q;
  logic [1:0]  idx_q;
  logic [1:0]  last_idx;
  logic        write_q;
  logic        size64_q;
  logic [63:0] rdata_q;
  logic [NocDataWidth-1:0] hdr;

  // take a new response only when idle
  assign rsp.ready   = ~busy_q;
  assign noc_valid_o = busy_q;

  // ack is header only, rdata carries one or two words
  assign last_idx = write_q ? 2'd0 : (size64_q ? 2'd2 : 2'd1);

  always_comb begin
    hdr                     = '0;
    hdr[HdrOpMsb:HdrOpLsb]  = write_q ? OpAck : OpRdata;
    hdr[HdrSizeBit]         = size64_q;
  end

  always_comb begin
    unique case (idx_q)
      2'd1:    noc_data_o = rdata_q[31:0];
      2'd2:    noc_data_o = rdata_q[63:32];
      default: noc_data_o = hdr;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      idx_q  <= '0;
    end else if (rsp.valid && rsp.ready) begin
      busy_q <= 1'b1;
      idx_q  <= '0;
    end else if (noc_valid_o && noc_ready_i) begin
      if (idx_q == last_idx) begin
        busy_q <= 1'b0;
      end else begin
        idx_q <= idx_q + 2'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rsp.valid && rsp.ready) begin
      write_q  <= rsp.data.write;
      size64_q <= rsp.data.size64;
      rdata_q  <= rsp.data.rdata;
    end
  end

endmodule

`default_nettype wire

/* design/hacd_pipe_reg.sv */
// one-entry valid/ready pipeline stage for any payload type
`default_nettype none

module hacd_pipe_reg #(
  parameter type payload_t = logic
) (
  input  wire logic clk_i,
  input  wire logic rst_ni,
  input  wire logic valid_i,
  output logic      ready_o,
  input  payload_t  data_i,
  output logic      valid_o,
  input  wire logic ready_i,
  output payload_t  data_o
);

  logic     valid_q;
  payload_t data_q;

  // free, or emptying in this very cycle
  assign ready_o = ~valid_q | ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

`default_nettype wire

/* design/hacd_reg_pkg.sv */
// register map and register bus types of the accelerator control block
`default_nettype none

package hacd_reg_pkg;

  ////////////////////////////////////////////////////////////
  // register offsets, relative to the accelerator base
  ////////////////////////////////////////////////////////////
  localparam logic [31:0] RegCtrl   = 32'h00;
  localparam logic [31:0] RegStatus = 32'h04;
  localparam logic [31:0] RegSrcLo  = 32'h08;
  localparam logic [31:0] RegSrcHi  = 32'h0C;
  localparam logic [31:0] RegLen    = 32'h10;
  localparam logic [31:0] RegJobCnt = 32'h14;

  // ctrl start bits
  localparam int unsigned CtrlDeflStart = 0;
  localparam int unsigned CtrlInflStart = 1;

  // status bits, done bits are write-1-to-clear
  localparam int unsigned StDeflBusy = 0;
  localparam int unsigned StInflBusy = 1;
  localparam int unsigned StDeflDone = 2;
  localparam int unsigned StInflDone = 3;

  typedef struct packed {
    logic        valid;
    logic        write;
    logic [31:0] addr;
    logic [31:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
  } reg_rsp_t;

endpackage

`default_nettype wire

/* design/hacd_top.sv */
// register front end of the compression accelerator, noc in to noc out
`default_nettype none

module hacd_top #(
  parameter logic [31:0] HacdBase = 32'h4000_0000,
  parameter int unsigned LenWidth = 8
) (
  input  wire logic                                  clk_i,
  input  wire logic                                  rst_ni,
  input  wire logic [hacd_noc_pkg::NocDataWidth-1:0] noc_in_data_i,
  input  wire logic                                  noc_in_valid_i,
  output logic                                       noc_in_ready_o,
  output logic [hacd_noc_pkg::NocDataWidth-1:0]      noc_out_data_o,
  output logic                                       noc_out_valid_o,
  input  wire logic                                  noc_out_ready_i,
  output logic                                       infl_irq_o,
  output logic                                       defl_irq_o
);

  import hacd_noc_pkg::*;

  acc_req_if rx_req ();
  acc_req_if split_req ();
  reg_bus_if reg_bus ();
  acc_rsp_if split_rsp ();
  acc_rsp_if tx_rsp ();

  ////////////////////////////////////////////////////////////
  // request path
  ////////////////////////////////////////////////////////////
  hacd_noc_rx i_noc_rx (
    .clk_i       ( clk_i          ),
    .rst_ni      ( rst_ni         ),
    .noc_data_i  ( noc_in_data_i  ),
    .noc_valid_i ( noc_in_valid_i ),
    .noc_ready_o ( noc_in_ready_o ),
    .req         ( rx_req.src     )
  );

  hacd_pipe_reg #(
    .payload_t ( acc_req_t )
  ) i_req_pipe (
    .clk_i   ( clk_i           ),
    .rst_ni  ( rst_ni          ),
    .valid_i ( rx_req.valid    ),
    .ready_o ( rx_req.ready    ),
    .data_i  ( rx_req.data     ),
    .valid_o ( split_req.valid ),
    .ready_i ( split_req.ready ),
    .data_o  ( split_req.data  )
  );

  hacd_word_split #(
    .HacdBase ( HacdBase )
  ) i_word_split (
    .clk_i  ( clk_i          ),
    .rst_ni ( rst_ni         ),
    .req    ( split_req.dst  ),
    .bus    ( reg_bus.mst    ),
    .rsp    ( split_rsp.src  )
  );

  hacd_ctrl_regs #(
    .LenWidth ( LenWidth )
  ) i_ctrl_regs (
    .clk_i      ( clk_i       ),
    .rst_ni     ( rst_ni      ),
    .bus        ( reg_bus.slv ),
    .infl_irq_o ( infl_irq_o  ),
    .defl_irq_o ( defl_irq_o  )
  );

  ////////////////////////////////////////////////////////////
  // response path
  ////////////////////////////////////////////////////////////
  hacd_pipe_reg #(
    .payload_t ( acc_rsp_t )
  ) i_rsp_pipe (
    .clk_i   ( clk_i           ),
    .rst_ni  ( rst_ni          ),
    .valid_i ( split_rsp.valid ),
    .ready_o ( split_rsp.ready ),
    .data_i  ( split_rsp.data  ),
    .valid_o ( tx_rsp.valid    ),
    .ready_i ( tx_rsp.ready    ),
    .data_o  ( tx_rsp.data     )
  );

  hacd_noc_tx i_noc_tx (
    .clk_i       ( clk_i           ),
    .rst_ni      ( rst_ni          ),
    .rsp         ( tx_rsp.dst      ),
    .noc_data_o  ( noc_out_data_o  ),
    .noc_valid_o ( noc_out_valid_o ),
    .noc_ready_i ( noc_out_ready_i )
  );

endmodule

`default_nettype wire

/* design/hacd_word_split.sv */
// address translation and split of each request into 32-bit register accesses
`default_nettype none

module hacd_word_split #(
  parameter logic [31:0] HacdBase = 32'h0000_0000
) (
  input  wire logic clk_i,
  input  wire logic rst_ni,
  acc_req_if.dst    req,
  reg_bus_if.mst    bus,
  acc_rsp_if.src    rsp
);

  typedef enum logic [1:0] {Idle, Second, Resp} state_e;

  state_e      state_d, state_q;
  logic [31:0] offset;
  logic        lo_en;
  logic        hi_en;
  logic [31:0] lo_q;
  logic [31:0] hi_q;
  logic        write_q;
  logic        size64_q;

  // offset inside the register block
  assign offset = req.data.addr - HacdBase;

  always_comb begin
    state_d       = state_q;
    req.ready     = 1'b0;
    rsp.valid     = 1'b0;
    lo_en         = 1'b0;
    hi_en         = 1'b0;
    bus.req.valid = 1'b0;
    bus.req.write = req.data.write;
    bus.req.addr  = offset;
    bus.req.wdata = req.data.wdata[31:0];

    unique case (state_q)
      Idle: begin
        if (req.valid && bus.rsp.ready) begin
          bus.req.valid = 1'b1;
          lo_en         = 1'b1;
          // a 64-bit access needs the high word in the next cycle
          if (req.data.size64) begin
            state_d = Second;
          end else begin
            req.ready = 1'b1;
            state_d   = Resp;
          end
        end
      end
      // high word at the next register
      Second: begin
        bus.req.addr  = offset + 32'h4;
        bus.req.wdata = req.data.wdata[63:32];
        if (bus.rsp.ready) begin
          bus.req.valid = 1'b1;
          hi_en         = 1'b1;
          req.ready     = 1'b1;
          state_d       = Resp;
        end
      end
      Resp: begin
        rsp.valid = 1'b1;
        if (rsp.ready) begin
          state_d = Idle;
        end
      end
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  // read words and response kind
  always_ff @(posedge clk_i) begin
    if (lo_en) begin
      lo_q     <= bus.rsp.rdata;
      hi_q     <= '0;
      write_q  <= req.data.write;
      size64_q <= req.data.size64;
    end
    if (hi_en) begin
      hi_q <= bus.rsp.rdata;
    end
  end

  assign rsp.data = '{write: write_q, size64: size64_q, rdata: {hi_q, lo_q}};

endmodule

`default_nettype wire

/* hacd_top.f */
+incdir+tb
design/hacd_noc_pkg.sv
design/hacd_reg_pkg.sv
design/hacd_if.sv
design/hacd_noc_rx.sv
design/hacd_pipe_reg.sv
design/hacd_word_split.sv
design/hacd_ctrl_regs.sv
design/hacd_noc_tx.sv
design/hacd_top.sv
tb/tb_hacd_top.sv

/* tb/hacd_model.svh */
// register and job model of the accelerator front end, with request packet builders
`ifndef HACD_MODEL_SVH
`define HACD_MODEL_SVH

  // model state, one entry per register in the map
  logic [31:0] m_src_lo;
  logic [31:0] m_src_hi;
  logic [7:0]  m_len;
  logic [31:0] m_job_cnt;
  logic [1:0]  m_busy;
  logic [1:0]  m_done;

  // flits still to send, and flits the noc output must produce, in order
  logic [31:0] pkt_q[$];
  logic [31:0] exp_q[$];

  function automatic void model_reset();
    m_src_lo  = '0;
    m_src_hi  = '0;
    m_len     = '0;
    m_job_cnt = '0;
    m_busy    = '0;
    m_done    = '0;
  endfunction

  function automatic void model_write(input logic [31:0] off, input logic [31:0] data);
    case (off)
      // start of an engine that is already busy changes nothing
      RegCtrl:   m_busy = m_busy | data[1:0];
      RegStatus: m_done = m_done & ~data[3:2];
      RegSrcLo:  m_src_lo = data;
      RegSrcHi:  m_src_hi = data;
      RegLen:    m_len = data[7:0];
      default:   ;
    endcase
  endfunction

  function automatic logic [31:0] model_read(input logic [31:0] off);
    case (off)
      RegStatus: return {28'h0, m_done, m_busy};
      RegSrcLo:  return m_src_lo;
      RegSrcHi:  return m_src_hi;
      RegLen:    return {24'h0, m_len};
      RegJobCnt: return m_job_cnt;
      default:   return 32'h0;
    endcase
  endfunction

  // engine 0 is deflate, engine 1 inflate
  function automatic void model_finish(input int eng);
    m_busy[eng] = 1'b0;
    m_done[eng] = 1'b1;
    m_job_cnt   = m_job_cnt + 32'h1;
  endfunction

  function automatic logic [31:0] hdr_flit(input logic [1:0] op, input logic size64);
    return {op, size64, 29'h0};
  endfunction

  function automatic void queue_write(input logic [31:0] off, input logic size64,
                                      input logic [63:0] data);
    pkt_q.push_back(hdr_flit(OpWrite, size64));
    pkt_q.push_back(HacdBase + off);
    pkt_q.push_back(data[31:0]);
    model_write(off, data[31:0]);
    if (size64) begin
      pkt_q.push_back(data[63:32]);
      model_write(off + 32'h4, data[63:32]);
    end
    exp_q.push_back(hdr_flit(OpAck, size64));
  endfunction

  function automatic void queue_read(input logic [31:0] off, input logic size64);
    pkt_q.push_back(hdr_flit(OpRead, size64));
    pkt_q.push_back(HacdBase + off);
    exp_q.push_back(hdr_flit(OpRdata, size64));
    exp_q.push_back(model_read(off));
    if (size64) begin
      exp_q.push_back(model_read(off + 32'h4));
    end
  endfunction

`endif

/* tb/tb_hacd_top.sv */
// testbench for the accelerator front end with random register traffic checked against a model
`default_nettype none

module tb_hacd_top;
  timeunit 1ns;
  timeprecision 1ps;

  import hacd_noc_pkg::*;
  import hacd_reg_pkg::*;

  localparam logic [31:0] HacdBase = 32'h4000_0000;
  localparam int          Timeout  = 2000;

  logic        clk_i;
  logic        rst_ni;
  logic [31:0] noc_in_data_i;
  logic        noc_in_valid_i;
  logic        noc_in_ready_o;
  logic [31:0] noc_out_data_o;
  logic        noc_out_valid_o;
  logic        noc_out_ready_i;
  logic        infl_irq_o;
  logic        defl_irq_o;

  integer      seed       = 32'h668a;
  int          errors     = 0;
  int          checks     = 0;
  int          ready_pct  = 70;
  logic        ready_next = 1'b0;
  logic [31:0] exp_flit;

  `include "hacd_model.svh"

  hacd_top #(
    .HacdBase ( HacdBase )
  ) DUT (
    .clk_i           ( clk_i           ),
    .rst_ni          ( rst_ni          ),
    .noc_in_data_i   ( noc_in_data_i   ),
    .noc_in_valid_i  ( noc_in_valid_i  ),
    .noc_in_ready_o  ( noc_in_ready_o  ),
    .noc_out_data_o  ( noc_out_data_o  ),
    .noc_out_valid_o ( noc_out_valid_o ),
    .noc_out_ready_i ( noc_out_ready_i ),
    .infl_irq_o      ( infl_irq_o      ),
    .defl_irq_o      ( defl_irq_o      )
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // checking and run control
  ////////////////////////////////////////////////////////////
  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic finish_run();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("timeout at %0t ns: %s", $time, what);
    finish_run();
  endtask

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  function automatic logic [31:0] data_reg_off();
    return RegSrcLo + 32'h4 * (rand_word() % 3);
  endfunction

  // unmapped offsets from 0x18 up to 0xf4
  function automatic logic [31:0] unmapped_off();
    return 32'h18 + 32'h4 * (rand_word() % 56);
  endfunction

  ////////////////////////////////////////////////////////////
  // noc input driver that starts and ends on a falling edge
  ////////////////////////////////////////////////////////////
  task automatic send_flit(input logic [31:0] flit);
    int waited;
    waited         = 0;
    noc_in_data_i  = flit;
    noc_in_valid_i = 1'b1;
    @(posedge clk_i);
    while (!noc_in_ready_o) begin
      waited++;
      if (waited > Timeout) report_timeout("request flit never accepted");
      @(posedge clk_i);
    end
    @(negedge clk_i);
    noc_in_valid_i = 1'b0;
  endtask

  task automatic send_packet();
    while (pkt_q.size() != 0) begin
      send_flit(pkt_q.pop_front());
    end
  endtask

  task automatic write_reg(input logic [31:0] off, input logic size64, input logic [63:0] data);
    queue_write(off, size64, data);
    send_packet();
  endtask

  task automatic read_reg(input logic [31:0] off, input logic size64);
    queue_read(off, size64);
    send_packet();
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      @(negedge clk_i);
      waited++;
      if (waited > Timeout) report_timeout("expected responses never left the noc output");
    end
  endtask

  task automatic wait_irq(input logic infl);
    int waited;
    waited = 0;
    while ((infl ? infl_irq_o : defl_irq_o) !== 1'b1) begin
      @(negedge clk_i);
      waited++;
      if (waited > Timeout) report_timeout("job interrupt never rose");
    end
  endtask

  // random back-pressure on the output
  always @(negedge clk_i) begin
    noc_out_ready_i <= ready_next;
  end

  // output collector comparing every accepted flit in order
  always @(posedge clk_i) begin
    if (rst_ni && noc_out_valid_o && noc_out_ready_i) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("output flit %h at %0t ns arrived with no response pending",
                 noc_out_data_o, $time);
      end else begin
        exp_flit = exp_q.pop_front();
        check_val("noc_out_data_o", noc_out_data_o, exp_flit);
      end
    end
    ready_next = ($unsigned($random(seed)) % 100) < ready_pct;
  end

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////
  initial begin
    logic [31:0] len;
    logic [31:0] off;
    logic [31:0] r;

    rst_ni          = 1'b0;
    noc_in_data_i   = '0;
    noc_in_valid_i  = 1'b0;
    noc_out_ready_i = 1'b0;
    model_reset();
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    check_val("noc_out_valid_o", noc_out_valid_o, 32'h0);
    check_val("noc_in_ready_o", noc_in_ready_o, 32'h1);
    check_val("infl_irq_o", infl_irq_o, 32'h0);
    check_val("defl_irq_o", defl_irq_o, 32'h0);

    // 32-bit writes and reads of the data registers
    repeat (20) begin
      off = data_reg_off();
      write_reg(off, 1'b0, {32'h0, rand_word()});
      read_reg(off, 1'b0);
    end
    wait_drained();

    // 64-bit access to the source address pair
    repeat (8) begin
      write_reg(RegSrcLo, 1'b1, {rand_word(), rand_word()});
      read_reg(RegSrcLo, 1'b0);
      read_reg(RegSrcHi, 1'b0);
      read_reg(RegSrcLo, 1'b1);
    end
    wait_drained();

    // deflate job long enough to see busy
    len = 32'd60 + rand_word() % 196;
    write_reg(RegLen, 1'b0, {32'h0, len});
    read_reg(RegJobCnt, 1'b0);
    write_reg(RegCtrl, 1'b0, 64'h1);
    read_reg(RegStatus, 1'b0);
    wait_drained();
    wait_irq(1'b0);
    model_finish(0);
    repeat (20) begin
      @(negedge clk_i);
      check_val("defl_irq_o", defl_irq_o, 32'h1);
    end
    read_reg(RegStatus, 1'b0);
    read_reg(RegJobCnt, 1'b0);
    wait_drained();

    // inflate job with a second start while busy
    len = 32'd60 + rand_word() % 196;
    write_reg(RegLen, 1'b0, {32'h0, len});
    write_reg(RegCtrl, 1'b0, 64'h2);
    write_reg(RegCtrl, 1'b0, 64'h2);
    read_reg(RegStatus, 1'b0);
    wait_drained();
    wait_irq(1'b1);
    model_finish(1);
    repeat (len + 10) @(negedge clk_i);
    read_reg(RegStatus, 1'b0);
    read_reg(RegJobCnt, 1'b0);
    wait_drained();
    write_reg(RegStatus, 1'b0, 64'hC);
    wait_drained();
    check_val("infl_irq_o", infl_irq_o, 32'h0);
    check_val("defl_irq_o", defl_irq_o, 32'h0);
    read_reg(RegStatus, 1'b0);

    // back to back mixed traffic under heavy back-pressure
    ready_pct = 25;
    repeat (60) begin
      r   = rand_word();
      off = (r[1:0] == 2'd3) ? unmapped_off() : data_reg_off();
      if (r[3]) begin
        write_reg(off, r[2], {rand_word(), rand_word()});
      end else begin
        read_reg(off, r[2]);
      end
    end
    repeat (8) read_reg(unmapped_off(), 1'b0);
    read_reg(RegCtrl, 1'b0);
    wait_drained();

    finish_run();
  end

endmodule

`default_nettype wire
